//--- common/sm83_bus_pkg.sv
package sm83_bus_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// interrupt flag and enable registers in the io page.
	localparam addr_t IF_ADDR = 16'hff0f;
	localparam addr_t IE_ADDR = 16'hffff;

	localparam data_t IF_UNUSED_MASK = 8'he0; // bits 7:5 not implemented, read high.

endpackage

//--- common/sm83_irq_pkg.sv
package sm83_irq_pkg;

	// source bits are vblank, lcd stat, timer, serial, joypad from bit 0 up.
	localparam int N_SRC = 5;
	localparam int IDX_W = 3;
	localparam int VEC_W = 16;
	localparam int CREDIT_W = 2;

	typedef logic [N_SRC-1:0] src_mask_t;
	typedef logic [IDX_W-1:0] src_idx_t;
	typedef logic [VEC_W-1:0] vector_t;
	typedef logic [CREDIT_W-1:0] credit_t;

	localparam vector_t VEC_BASE = 16'h0040;
	localparam vector_t VEC_STRIDE = 16'd8;

	localparam credit_t CREDITS = 2'd1; // vectors the core can hold.

	typedef enum logic {
		IDLE,
		WAIT_CREDIT
	} disp_state_t;

	// one-hot mask for a source index.
	function automatic src_mask_t src_bit(input src_idx_t idx);
		return src_mask_t'(1) << idx;
	endfunction

endpackage

//--- common/irq_path_if.sv
`timescale 1ns/1ps
`default_nettype none

interface irq_path_if;

	sm83_irq_pkg::src_mask_t pending; // IF and IE anded.
	logic                    win_valid;
	sm83_irq_pkg::src_idx_t  win_idx;
	logic                    ack; // one cycle, same edge as irq_valid.
	sm83_irq_pkg::src_idx_t  ack_idx;

	modport regs (
		output pending,
		input  ack,
		input  ack_idx
	);

	// prio sees the ack so the bit being cleared is not picked again.
	modport prio (
		input  pending,
		input  ack,
		input  ack_idx,
		output win_valid,
		output win_idx
	);

	modport dispatch (
		input  win_valid,
		input  win_idx,
		output ack,
		output ack_idx
	);

endinterface

`default_nettype wire

//--- verilog/sm83_irq_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_irq_regs (
		input  logic                    clk,
		input  logic                    reset,
		input  sm83_bus_pkg::addr_t     addr,
		input  sm83_bus_pkg::data_t     wdata,
		input  logic                    we,
		input  logic                    re,
		output sm83_bus_pkg::data_t     rdata,
		input  sm83_irq_pkg::src_mask_t src_req,
		irq_path_if.regs                path
	);

	logic                    hit_if;
	logic                    hit_ie;
	sm83_irq_pkg::src_mask_t if_q;
	sm83_irq_pkg::src_mask_t if_next;
	sm83_irq_pkg::src_mask_t ack_mask;
	sm83_bus_pkg::data_t     ie_q;
	sm83_bus_pkg::data_t     rd_mux;

	assign hit_if = (addr == sm83_bus_pkg::IF_ADDR);
	assign hit_ie = (addr == sm83_bus_pkg::IE_ADDR);

	assign ack_mask = path.ack ? sm83_irq_pkg::src_bit(path.ack_idx) : '0;

	always_comb begin
		if_next = if_q & ~ack_mask; // clear the dispatched source.
		if (we && hit_if) begin
			if_next = wdata[sm83_irq_pkg::N_SRC-1:0]; // cpu write replaces the flags.
		end
		// a request in the same cycle beats both the clear and the write.
		if_next = if_next | src_req;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			if_q <= '0;
		end else begin
			if_q <= if_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ie_q <= '0;
		end else if (we && hit_ie) begin
			ie_q <= wdata; // all eight bits kept.
		end
	end

	always_comb begin
		rd_mux = '1; // open bus.
		if (hit_if) begin
			rd_mux = sm83_bus_pkg::IF_UNUSED_MASK | sm83_bus_pkg::data_t'(if_q);
		end else if (hit_ie) begin
			rd_mux = ie_q;
		end
	end

	always_ff @(posedge clk) begin
		if (re) begin
			rdata <= rd_mux;
		end
	end

	assign path.pending = if_q & ie_q[sm83_irq_pkg::N_SRC-1:0];

	// a source pulse always lands in IF, whatever the bus or the ack does.
	a_req_kept: assert property (@(posedge clk) disable iff (reset)
		src_req != '0 |=> (if_q & $past(src_req)) == $past(src_req));

endmodule

`default_nettype wire

//--- verilog/sm83_irq_prio.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_irq_prio (
		input logic      clk,
		input logic      reset,
		irq_path_if.prio path
	);

	sm83_irq_pkg::src_mask_t ack_mask;
	sm83_irq_pkg::src_mask_t cand;
	logic                    any;
	sm83_irq_pkg::src_idx_t  first;

	// the acked bit leaves IF only on the next edge, so mask it here.
	assign ack_mask = path.ack ? sm83_irq_pkg::src_bit(path.ack_idx) : '0;
	assign cand = path.pending & ~ack_mask;

	// scanning from the top leaves the lowest set index in first.
	always_comb begin
		any = 1'b0;
		first = '0;
		for (int i = sm83_irq_pkg::N_SRC - 1; i >= 0; i--) begin
			if (cand[i]) begin
				any = 1'b1;
				first = sm83_irq_pkg::src_idx_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			path.win_valid <= 1'b0;
		end else begin
			path.win_valid <= any;
		end
	end

	always_ff @(posedge clk) begin
		path.win_idx <= first;
	end

	// the winner was pending and no lower source was a candidate.
	a_win_pending: assert property (@(posedge clk) disable iff (reset)
		path.win_valid |->
			((($past(path.pending) & sm83_irq_pkg::src_bit(path.win_idx)) != '0) &&
			(($past(cand) & (sm83_irq_pkg::src_bit(path.win_idx) -
				sm83_irq_pkg::src_mask_t'(1))) == '0)));

endmodule

`default_nettype wire

//--- verilog/sm83_irq_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_irq_dispatch (
		input  logic                  clk,
		input  logic                  reset,
		input  logic                  ime_set,
		input  logic                  ime_clear,
		output logic                  irq_valid,
		output sm83_irq_pkg::vector_t irq_vector,
		input  logic                  irq_credit,
		irq_path_if.dispatch          path
	);

	logic                      ime;
	logic                      want;
	logic                      issue;
	sm83_irq_pkg::credit_t     credits;
	sm83_irq_pkg::disp_state_t state;
	sm83_irq_pkg::disp_state_t state_next;
	sm83_irq_pkg::vector_t     vector_next;

	assign want = path.win_valid && ime;
	assign issue = want && (credits != '0) && (state == sm83_irq_pkg::IDLE);

	// 0x40 + 8 * index.
	assign vector_next = sm83_irq_pkg::VEC_BASE +
		sm83_irq_pkg::VEC_STRIDE * sm83_irq_pkg::vector_t'(path.win_idx);

	always_ff @(posedge clk) begin
		if (reset) begin
			ime <= 1'b0;
		end else if (ime_clear || issue) begin
			ime <= 1'b0; // di wins over ei and dispatch drops ime.
		end else if (ime_set) begin
			ime <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= sm83_irq_pkg::CREDITS;
		end else if (issue && !irq_credit) begin
			credits <= credits - sm83_irq_pkg::credit_t'(1);
		end else if (!issue && irq_credit) begin
			credits <= credits + sm83_irq_pkg::credit_t'(1);
		end
	end

	// parked here while a winner waits for the core to return a credit.
	always_comb begin
		state_next = state;
		case (state)
			sm83_irq_pkg::IDLE: begin
				if (want && credits == '0 && !irq_credit) begin
					state_next = sm83_irq_pkg::WAIT_CREDIT;
				end
			end
			sm83_irq_pkg::WAIT_CREDIT: begin
				if (irq_credit || !want) begin
					state_next = sm83_irq_pkg::IDLE;
				end
			end
			default: state_next = sm83_irq_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sm83_irq_pkg::IDLE;
			irq_valid <= 1'b0;
		end else begin
			state <= state_next;
			irq_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			irq_vector <= vector_next;
			path.ack_idx <= path.win_idx;
		end
	end

	assign path.ack = irq_valid; // regs clears IF on the following edge.

	a_wait_no_credit: assert property (@(posedge clk) disable iff (reset)
		state == sm83_irq_pkg::WAIT_CREDIT |-> credits == '0);

	a_credit_max: assert property (@(posedge clk) disable iff (reset)
		credits <= sm83_irq_pkg::CREDITS);

endmodule

`default_nettype wire

//--- verilog/sm83_irq_top.sv
`timescale 1ns/1ps
`default_nettype none

module sm83_irq_top (
		input  logic                    clk,
		input  logic                    reset,
		input  sm83_bus_pkg::addr_t     addr,
		input  sm83_bus_pkg::data_t     wdata,
		input  logic                    we,
		input  logic                    re,
		output sm83_bus_pkg::data_t     rdata,
		input  sm83_irq_pkg::src_mask_t src_req,
		input  logic                    ime_set,
		input  logic                    ime_clear,
		output logic                    irq_valid,
		output sm83_irq_pkg::vector_t   irq_vector,
		input  logic                    irq_credit
	);

	irq_path_if u_path ();

	sm83_irq_regs u_regs (
		.clk     (clk),
		.reset   (reset),
		.addr    (addr),
		.wdata   (wdata),
		.we      (we),
		.re      (re),
		.rdata   (rdata),
		.src_req (src_req),
		.path    (u_path.regs)
	);

	sm83_irq_prio u_prio (
		.clk   (clk),
		.reset (reset),
		.path  (u_path.prio)
	);

	sm83_irq_dispatch u_dispatch (
		.clk        (clk),
		.reset      (reset),
		.ime_set    (ime_set),
		.ime_clear  (ime_clear),
		.irq_valid  (irq_valid),
		.irq_vector (irq_vector),
		.irq_credit (irq_credit),
		.path       (u_path.dispatch)
	);

endmodule

`default_nettype wire

//--- dv/sm83_irq_tb.sv
`timescale 1ns/1ps

module sm83_irq_tb;

	localparam int MAX_STEPS = 128;
	localparam int LINE_W = 4; // op, arg, data, expect.

	localparam logic [15:0] OP_TEST = 16'h0;
	localparam logic [15:0] OP_WRITE = 16'h1;
	localparam logic [15:0] OP_READ = 16'h2;
	localparam logic [15:0] OP_SOURCE = 16'h3;
	localparam logic [15:0] OP_IME_SET = 16'h4;
	localparam logic [15:0] OP_IME_CLEAR = 16'h5;
	localparam logic [15:0] OP_CREDIT = 16'h6;
	localparam logic [15:0] OP_WAIT = 16'h7;
	localparam logic [15:0] OP_VECTOR = 16'h8;
	localparam logic [15:0] OP_QUIET = 16'h9;
	localparam logic [15:0] OP_END = 16'hf;

	logic                    clk;
	logic                    reset;
	sm83_bus_pkg::addr_t     addr;
	sm83_bus_pkg::data_t     wdata;
	logic                    we;
	logic                    re;
	sm83_bus_pkg::data_t     rdata;
	sm83_irq_pkg::src_mask_t src_req;
	logic                    ime_set;
	logic                    ime_clear;
	logic                    irq_valid;
	sm83_irq_pkg::vector_t   irq_vector;
	logic                    irq_credit;

	logic [15:0] golden [MAX_STEPS * LINE_W];
	string       test_name;
	int          step;
	int          steps_total;
	int          limit_cycles = 0;
	int          vec_count = 0;
	int          vec_expected = 0;
	logic        failed;

	initial clk = 1'b0;
	always #2 clk = ~clk;

	sm83_irq_top u_sm83_irq_top (
		.clk        (clk),
		.reset      (reset),
		.addr       (addr),
		.wdata      (wdata),
		.we         (we),
		.re         (re),
		.rdata      (rdata),
		.src_req    (src_req),
		.ime_set    (ime_set),
		.ime_clear  (ime_clear),
		.irq_valid  (irq_valid),
		.irq_vector (irq_vector),
		.irq_credit (irq_credit)
	);

	// core model that takes every vector it is sent.
	always @(negedge clk) begin
		if (!reset && irq_valid) begin
			vec_count <= vec_count + 1;
		end
	end

	function automatic string test_label(input int id);
		case (id)
			1: return "reg_access";
			2: return "priority";
			3: return "masking";
			4: return "ime_gating";
			5: return "credit_backpressure";
			6: return "latency";
			default: return "unnamed";
		endcase
	endfunction

	task automatic stop_failed();
		failed = 1'b1;
		$display("TB FAILED");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic check(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("** Error: test %s, step %0d, %s: expected %0h, actual %0h",
				test_name, step, what, expected, actual);
			stop_failed();
		end
	endtask

	// step one clock and drop the pulse inputs after the edge.
	task automatic next_cycle();
		@(posedge clk);
		#1;
		we = 1'b0;
		re = 1'b0;
		src_req = '0;
		ime_set = 1'b0;
		ime_clear = 1'b0;
		irq_credit = 1'b0;
	endtask

	task automatic load_golden();
		int base;
		int wait_len;
		int max_wait;
		$readmemh("dv/sm83_irq_golden.txt", golden);
		steps_total = 0;
		max_wait = 1;
		while (steps_total < MAX_STEPS && golden[steps_total * LINE_W] != OP_END) begin
			base = steps_total * LINE_W;
			wait_len = 0;
			if (golden[base] == OP_WAIT || golden[base] == OP_QUIET) begin
				wait_len = int'(golden[base + 1]);
			end else if (golden[base] == OP_VECTOR) begin
				wait_len = int'(golden[base + 2]); // last cycle of the window.
			end
			if (wait_len > max_wait) begin
				max_wait = wait_len;
			end
			steps_total++;
		end
		limit_cycles = (steps_total + 1) * max_wait + 100;
		if (steps_total == MAX_STEPS) begin
			$display("golden file has no end line within %0d steps", MAX_STEPS);
			stop_failed();
		end
	endtask

	// cycle 1 is the sample point right after the previous drive.
	task automatic expect_vector(input int lo, input int hi, input logic [15:0] vec);
		int   c;
		logic seen;
		seen = 1'b0;
		for (c = 1; c <= hi && !seen; c++) begin
			if (c > 1) begin
				next_cycle();
			end
			if (irq_valid) begin
				seen = 1'b1;
				if (c < lo) begin
					$display("test %s, step %0d: vector came in cycle %0d, before cycle %0d",
						test_name, step, c, lo);
					stop_failed();
				end else begin
					check("irq_vector", 32'(vec), 32'(irq_vector));
					vec_expected++;
				end
			end
		end
		if (!seen) begin
			$display("test %s, step %0d: no vector within %0d cycles", test_name, step, hi);
			stop_failed();
		end
	endtask

	task automatic expect_quiet(input int n);
		int c;
		for (c = 1; c <= n; c++) begin
			if (c > 1) begin
				next_cycle();
			end
			check("irq_valid", 32'd0, 32'(irq_valid));
		end
	endtask

	task automatic run_step();
		logic [15:0] op;
		logic [15:0] arg;
		logic [15:0] arg2;
		logic [15:0] exp_v;
		op = golden[step * LINE_W];
		arg = golden[step * LINE_W + 1];
		arg2 = golden[step * LINE_W + 2];
		exp_v = golden[step * LINE_W + 3];
		case (op)
			OP_TEST: test_name = test_label(int'(arg));
			OP_WRITE: begin
				addr = arg;
				wdata = arg2[7:0];
				we = 1'b1;
				next_cycle();
			end
			OP_READ: begin
				addr = arg;
				re = 1'b1;
				next_cycle(); // rdata is registered on this edge.
				check("rdata", 32'(exp_v), 32'(rdata));
			end
			OP_SOURCE: begin
				src_req = arg[sm83_irq_pkg::N_SRC-1:0];
				next_cycle();
			end
			OP_IME_SET: begin
				ime_set = 1'b1;
				next_cycle();
			end
			OP_IME_CLEAR: begin
				ime_clear = 1'b1;
				next_cycle();
			end
			OP_CREDIT: begin
				irq_credit = 1'b1;
				next_cycle();
			end
			OP_WAIT: repeat (int'(arg)) next_cycle();
			OP_VECTOR: expect_vector(int'(arg), int'(arg2), exp_v);
			OP_QUIET: expect_quiet(int'(arg));
			default: begin
				$display("unknown operation %0h on golden step %0d", op, step);
				stop_failed();
			end
		endcase
	endtask

	initial begin
		addr = '0;
		wdata = '0;
		we = 1'b0;
		re = 1'b0;
		src_req = '0;
		ime_set = 1'b0;
		ime_clear = 1'b0;
		irq_credit = 1'b0;
		reset = 1'b1;
		failed = 1'b0;
		step = 0;
		test_name = "reset";
		load_golden();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (step = 0; step < steps_total; step++) begin
			run_step();
		end
		next_cycle();
		test_name = "summary";
		check("vectors received", 32'(vec_expected), 32'(vec_count));
		if (!failed) begin
			$display("TB PASSED");
			$finish;
		end else begin
			stop_failed();
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", limit_cycles);
		stop_failed();
	end

endmodule

//--- sm83_irq.f
common/sm83_bus_pkg.sv
common/sm83_irq_pkg.sv
common/irq_path_if.sv
verilog/sm83_irq_regs.sv
verilog/sm83_irq_prio.sv
verilog/sm83_irq_dispatch.sv
verilog/sm83_irq_top.sv
dv/sm83_irq_tb.sv

//--- Makefile
TOP := sm83_irq_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sm83_irq.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/sm83_irq_golden.txt
// columns: op arg data expect, all hex
// op 0 test id, 1 write addr data, 2 read addr expect, 3 source mask, 4 ime set,
// 5 ime clear, 6 credit, 7 wait n, 8 vector in cycles arg..data, 9 no vector n, f end
// register access
0 1 0 0
2 ff0f 0 e0
2 ffff 0 0
1 ffff a5 0
2 ffff 0 a5
1 ff0f 0a 0
2 ff0f 0 ea
1 ff0f ff 0
2 ff0f 0 ff
1 ff0f 0 0
2 ff0f 0 e0
// vblank, timer and joypad in one cycle
0 2 0 0
1 ffff 1f 0
4 0 0 0
3 15 0 0
8 1 8 40
7 1 0 0
2 ff0f 0 f4
6 0 0 0
4 0 0 0
8 1 8 50
7 1 0 0
2 ff0f 0 f0
6 0 0 0
4 0 0 0
8 1 8 60
7 1 0 0
2 ff0f 0 e0
6 0 0 0
// timer flagged while disabled
0 3 0 0
1 ffff 1b 0
4 0 0 0
3 04 0 0
9 a 0 0
2 ff0f 0 e4
1 ffff 1f 0
8 1 8 50
7 1 0 0
2 ff0f 0 e0
6 0 0 0
// ime gating
0 4 0 0
4 0 0 0
5 0 0 0
3 02 0 0
9 14 0 0
2 ff0f 0 e2
4 0 0 0
8 1 3 48
6 0 0 0
3 08 0 0
9 c 0 0
4 0 0 0
8 1 3 58
7 1 0 0
2 ff0f 0 e0
6 0 0 0
// no credit until the core returns it
0 5 0 0
4 0 0 0
3 01 0 0
8 1 8 40
4 0 0 0
3 10 0 0
9 a 0 0
2 ff0f 0 f0
6 0 0 0
8 2 2 60
7 1 0 0
2 ff0f 0 e0
6 0 0 0
// source to vector latency
0 6 0 0
4 0 0 0
3 08 0 0
8 3 3 58
7 1 0 0
2 ff0f 0 e0
6 0 0 0
f 0 0 0
